//--- rtl/sprite_pkg.sv
`default_nettype none

package sprite_pkg;

	// Widths that carry a meaning
	typedef logic [8:0] pos_t;
	typedef logic [9:0] lb_addr_t;
	typedef logic [15:0] colour_t;
	typedef logic [16:0] rom_addr_t;
	typedef logic [7:0] ram_addr_t;
	typedef logic [7:0] pal_addr_t;
	typedef logic [5:0] sprite_index_t;
	typedef logic [5:0] size_px_t;

	localparam int NUM_SPRITES = 64;
	localparam int SPRITE_BYTES = 4;
	localparam pos_t BORDER = 9'd32;
	localparam pos_t LINE_WRAP_VCNT = 9'd255;
	localparam int READ_PHASES = 4;

	// Image regions in sprite ROM, one per sprite size
	localparam rom_addr_t ROM_BASE_8 = 17'd0;
	localparam rom_addr_t ROM_BASE_16 = 17'd8192;
	localparam rom_addr_t ROM_BASE_32 = 17'd24576;

	// Sprite RAM bit positions in bytes 0 and 2
	localparam int B0_ENABLE = 7;
	localparam int B0_PALETTE = 4;
	localparam int B0_SIZE = 2;
	localparam int B0_MIRROR = 1;
	localparam int B0_Y_MSB = 0;
	localparam int B2_IMAGE = 1;
	localparam int B2_X_MSB = 0;

	typedef enum logic [1:0] {
		SIZE_32 = 2'd0,
		SIZE_16 = 2'd1,
		SIZE_8 = 2'd2,
		SIZE_INVALID = 2'd3
	} size_code_t;

	localparam size_px_t PX_8 = 6'd8;
	localparam size_px_t PX_16 = 6'd16;
	localparam size_px_t PX_32 = 6'd32;

	typedef struct packed {
		pos_t x;
		pos_t y;
		size_px_t size;
		logic [6:0] image;
		logic [1:0] palette;
		logic mirror;
	} sprite_desc_t;

	typedef enum logic [3:0] {
		S_IDLE,
		S_WAIT,
		S_BYTE0,
		S_BYTE1,
		S_BYTE2,
		S_BYTE3,
		S_REQ,
		S_RELEASE,
		S_DONE
	} scan_state_t;

	typedef enum logic [1:0] {
		R_IDLE,
		R_FETCH,
		R_DRAIN,
		R_ACK
	} render_state_t;

endpackage

`default_nettype wire

//--- rtl/line_buffer_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module line_buffer_ctrl
	import sprite_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire hsync,
	input wire pos_t hcnt,
	input wire pos_t vcnt,
	input wire colour_t lb_rd_data,
	input wire line_ack,
	output logic line_req,
	output pos_t active_y,
	output logic lb_slot_wr,
	output lb_addr_t lb_rd_addr,
	output logic lb_rd_clear,
	output logic [7:0] r,
	output logic [7:0] g,
	output logic [7:0] b,
	output logic a
);

	logic hsync_last;
	logic hsync_rise;
	logic pending;
	logic start;
	logic slot_rd;
	logic [$clog2(READ_PHASES)-1:0] phase;

	assign hsync_rise = hsync && !hsync_last;

	// A line only starts once the previous handshake has fully closed
	assign start = (hsync_rise || pending) && !line_req && !line_ack;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hsync_last <= 1'b0;
			pending <= 1'b0;
			line_req <= 1'b0;
			slot_rd <= 1'b0;
			lb_slot_wr <= 1'b1;
		end
		else
		begin
			hsync_last <= hsync;
			pending <= (hsync_rise || pending) && !start;
			if (start)
			begin
				// Swap read and write slots
				slot_rd <= ~slot_rd;
				lb_slot_wr <= ~lb_slot_wr;
				line_req <= 1'b1;
			end
			else if (line_req && line_ack)
				line_req <= 1'b0;
		end
	end

	// Next visible line, wrapping back to the top border
	always_ff @(posedge clk)
	begin
		if (start)
			active_y <= (vcnt == LINE_WRAP_VCNT) ? BORDER : vcnt + BORDER + pos_t'(1);
	end

	assign lb_rd_addr = {slot_rd, hcnt + BORDER};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase <= '0;
			lb_rd_clear <= 1'b0;
		end
		else
		begin
			phase <= phase + 1'b1;
			lb_rd_clear <= (phase == '0);
		end
	end

	// 5-bit fields widened by repeating their top bits
	always_ff @(posedge clk)
	begin
		if (phase == '0)
		begin
			r <= {lb_rd_data[4:0], lb_rd_data[4:2]};
			g <= {lb_rd_data[9:5], lb_rd_data[9:7]};
			b <= {lb_rd_data[14:10], lb_rd_data[14:12]};
			a <= lb_rd_data[15];
		end
	end

endmodule

`default_nettype wire

//--- rtl/sprite_scanner.sv
`timescale 1ns/1ns
`default_nettype none

module sprite_scanner
	import sprite_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire line_req,
	input wire pos_t active_y,
	input wire [7:0] ram_data,
	input wire spr_ack,
	output logic line_ack,
	output ram_addr_t ram_addr,
	output logic spr_req,
	output sprite_desc_t spr,
	output pos_t row
);

	scan_state_t state;
	sprite_index_t index;
	sprite_index_t next_index;
	size_code_t size_code;
	size_px_t size_px;
	pos_t y_cur;
	logic [9:0] y_last;
	logic on_line;
	logic drop_b0;
	logic advance;
	logic last;

	assign size_code = size_code_t'(ram_data[B0_SIZE +: 2]);
	assign drop_b0 = !ram_data[B0_ENABLE] || size_code == SIZE_INVALID;

	always_comb
	begin
		case (size_code)
			SIZE_8: size_px = PX_8;
			SIZE_16: size_px = PX_16;
			SIZE_32: size_px = PX_32;
			default: size_px = '0;
		endcase
	end

	// Y test while byte 1 is on the bus
	assign y_cur = {spr.y[8], ram_data};
	assign y_last = {1'b0, y_cur} + {4'b0, spr.size} - 10'd1;
	assign on_line = (active_y >= y_cur) && ({1'b0, active_y} <= y_last);

	assign advance = (state == S_BYTE0 && drop_b0)
		|| (state == S_BYTE1 && !on_line)
		|| (state == S_RELEASE && !spr_ack);
	assign last = (index == sprite_index_t'(NUM_SPRITES - 1));
	assign next_index = index + 1'b1;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			line_ack <= 1'b0;
			spr_req <= 1'b0;
		end
		else
		begin
			case (state)
				S_IDLE:
					if (line_req)
						state <= S_WAIT;
				S_WAIT: state <= S_BYTE0;
				S_BYTE0: state <= S_BYTE1;
				S_BYTE1: state <= S_BYTE2;
				S_BYTE2: state <= S_BYTE3;
				S_BYTE3:
				begin
					spr_req <= 1'b1;
					state <= S_REQ;
				end
				S_REQ:
					if (spr_ack)
					begin
						spr_req <= 1'b0;
						state <= S_RELEASE;
					end
				S_DONE:
					if (!line_req)
					begin
						line_ack <= 1'b0;
						state <= S_IDLE;
					end
				default: ;
			endcase
			// Rejected or finished sprites leave from here
			if (advance)
			begin
				if (last)
				begin
					line_ack <= 1'b1;
					state <= S_DONE;
				end
				else
					state <= S_WAIT;
			end
		end
	end

	// Sprite RAM address, one byte per cycle through a descriptor
	always_ff @(posedge clk)
	begin
		if (state == S_IDLE)
		begin
			index <= '0;
			ram_addr <= '0;
		end
		else if (advance)
		begin
			index <= next_index;
			ram_addr <= ram_addr_t'(next_index) * ram_addr_t'(SPRITE_BYTES);
		end
		else if (state == S_WAIT || state == S_BYTE0 || state == S_BYTE1)
			ram_addr <= ram_addr + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		case (state)
			S_BYTE0:
			begin
				spr.palette <= ram_data[B0_PALETTE +: 2];
				spr.size <= size_px;
				spr.mirror <= ram_data[B0_MIRROR];
				spr.y[8] <= ram_data[B0_Y_MSB];
			end
			S_BYTE1:
			begin
				spr.y[7:0] <= ram_data;
				row <= active_y - y_cur;
			end
			S_BYTE2:
			begin
				spr.image <= ram_data[B2_IMAGE +: 7];
				spr.x[8] <= ram_data[B2_X_MSB];
			end
			S_BYTE3: spr.x[7:0] <= ram_data;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/sprite_renderer.sv
`timescale 1ns/1ns
`default_nettype none

module sprite_renderer
	import sprite_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire spr_req,
	input wire sprite_desc_t spr,
	input wire pos_t row,
	input wire lb_slot_wr,
	input wire [7:0] rom_data,
	input wire colour_t pal_data,
	output logic spr_ack,
	output rom_addr_t rom_addr,
	output pal_addr_t pal_addr,
	output lb_addr_t lb_wr_addr,
	output colour_t lb_wr_data,
	output logic lb_wr
);

	render_state_t state;

	// Pixel pipeline: ROM address out, ROM data and palette address, palette data
	logic [2:0] stage;
	logic issue;
	size_px_t remaining;
	size_px_t pix;
	rom_addr_t base;
	rom_addr_t size_r;
	rom_addr_t start_addr;

	always_comb
	begin
		case (spr.size)
			PX_8: base = ROM_BASE_8;
			PX_16: base = ROM_BASE_16;
			default: base = ROM_BASE_32;
		endcase
	end

	// Mirrored rows start from the last pixel and walk backwards
	assign size_r = rom_addr_t'(spr.size);
	assign start_addr = base
		+ rom_addr_t'(spr.image) * size_r * size_r
		+ rom_addr_t'(row) * size_r
		+ (spr.mirror ? size_r - rom_addr_t'(1) : rom_addr_t'(0));

	assign issue = (state == R_IDLE && spr_req) || (state == R_FETCH && remaining != '0);

	// ROM output is registered, so the palette lookup follows it directly
	assign pal_addr = {spr.palette, rom_data[4:0], 1'b0};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= R_IDLE;
			stage <= '0;
			spr_ack <= 1'b0;
			lb_wr <= 1'b0;
		end
		else
		begin
			stage <= {stage[1:0], issue};
			// Transparent pixels are dropped here
			lb_wr <= stage[2] && pal_data[15];
			case (state)
				R_IDLE:
					if (spr_req)
						state <= R_FETCH;
				R_FETCH:
					if (remaining == '0)
						state <= R_DRAIN;
				R_DRAIN:
					// Last write is on the bus this cycle
					if (stage == '0)
					begin
						spr_ack <= 1'b1;
						state <= R_ACK;
					end
				R_ACK:
					if (!spr_req)
					begin
						spr_ack <= 1'b0;
						state <= R_IDLE;
					end
				default: state <= R_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == R_IDLE)
		begin
			rom_addr <= start_addr;
			remaining <= spr.size - 1'b1;
			pix <= '0;
		end
		else if (issue)
		begin
			rom_addr <= spr.mirror ? rom_addr - 1'b1 : rom_addr + 1'b1;
			remaining <= remaining - 1'b1;
		end
		if (stage[2])
		begin
			lb_wr_addr <= {lb_slot_wr, spr.x + pos_t'(pix)};
			lb_wr_data <= pal_data;
			pix <= pix + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/sprite_engine.sv
`timescale 1ns/1ns
`default_nettype none

module sprite_engine
	import sprite_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire hsync,
	input wire pos_t hcnt,
	input wire pos_t vcnt,
	input wire [7:0] ram_data,
	input wire [7:0] rom_data,
	input wire colour_t pal_data,
	input wire colour_t lb_rd_data,
	output ram_addr_t ram_addr,
	output rom_addr_t rom_addr,
	output pal_addr_t pal_addr,
	output lb_addr_t lb_wr_addr,
	output lb_addr_t lb_rd_addr,
	output colour_t lb_wr_data,
	output logic lb_wr,
	output logic lb_rd_clear,
	output logic [7:0] r,
	output logic [7:0] g,
	output logic [7:0] b,
	output logic a
);

	// Line handshake
	logic line_req;
	logic line_ack;
	pos_t active_y;
	logic lb_slot_wr;

	// Sprite handshake
	logic spr_req;
	logic spr_ack;
	sprite_desc_t spr;
	pos_t row;

	line_buffer_ctrl u_line_ctrl (
		.clk(clk),
		.reset(reset),
		.hsync(hsync),
		.hcnt(hcnt),
		.vcnt(vcnt),
		.lb_rd_data(lb_rd_data),
		.line_ack(line_ack),
		.line_req(line_req),
		.active_y(active_y),
		.lb_slot_wr(lb_slot_wr),
		.lb_rd_addr(lb_rd_addr),
		.lb_rd_clear(lb_rd_clear),
		.r(r),
		.g(g),
		.b(b),
		.a(a)
	);

	sprite_scanner u_scanner (
		.clk(clk),
		.reset(reset),
		.line_req(line_req),
		.active_y(active_y),
		.ram_data(ram_data),
		.spr_ack(spr_ack),
		.line_ack(line_ack),
		.ram_addr(ram_addr),
		.spr_req(spr_req),
		.spr(spr),
		.row(row)
	);

	sprite_renderer u_renderer (
		.clk(clk),
		.reset(reset),
		.spr_req(spr_req),
		.spr(spr),
		.row(row),
		.lb_slot_wr(lb_slot_wr),
		.rom_data(rom_data),
		.pal_data(pal_data),
		.spr_ack(spr_ack),
		.rom_addr(rom_addr),
		.pal_addr(pal_addr),
		.lb_wr_addr(lb_wr_addr),
		.lb_wr_data(lb_wr_data),
		.lb_wr(lb_wr)
	);

endmodule

`default_nettype wire

//--- tb/sprite_engine_tb.sv
`timescale 1ns/1ns
`default_nettype none

module sprite_engine_tb
	import sprite_pkg::*;
();

	localparam int LINE_CYCLES = 1000;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_LINES = 10;
	localparam int READ_COUNT = 64;
	localparam int TIMEOUT_CYCLES = (NUM_LINES + 2) * LINE_CYCLES + RESET_CYCLES;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic hsync = 1'b0;
	pos_t hcnt = '0;
	pos_t vcnt = '0;
	logic [7:0] ram_data = '0;
	logic [7:0] rom_data = '0;
	colour_t pal_data = '0;
	colour_t lb_rd_data = '0;
	ram_addr_t ram_addr;
	rom_addr_t rom_addr;
	pal_addr_t pal_addr;
	lb_addr_t lb_wr_addr;
	lb_addr_t lb_rd_addr;
	colour_t lb_wr_data;
	logic lb_wr;
	logic lb_rd_clear;
	logic [7:0] r;
	logic [7:0] g;
	logic [7:0] b;
	logic a;

	// External memories
	logic [7:0] sprite_ram [0:255];
	logic [7:0] sprite_rom [0:131071];
	colour_t palette [0:255];
	colour_t line_buf [0:1023];

	integer seed = 32'hcc8e;
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int cycles = 0;
	logic [1:0] phase = '0;
	pos_t exp_y = '0;
	logic exp_slot = 1'b1;
	event line_end;

	sprite_engine dut (.*);

	always #50 clk = ~clk;

	// One cycle of read latency on every port
	always @(posedge clk)
	begin
		ram_data <= sprite_ram[ram_addr];
		rom_data <= sprite_rom[rom_addr];
		pal_data <= palette[pal_addr];
		lb_rd_data <= line_buf[lb_rd_addr];
		if (lb_wr)
			line_buf[lb_wr_addr] <= lb_wr_data;
		if (lb_rd_clear)
			line_buf[lb_rd_addr] <= '0;
	end

	// Readout phase counts freely from reset
	always @(posedge clk)
	begin
		if (reset)
			phase <= '0;
		else
			phase <= phase + 2'd1;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Run timed out after %0d cycles before all tests finished", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// Colour of one pixel on a line, drawn from the memory contents
	function automatic colour_t expected_pixel(input pos_t ay, input pos_t px);
		colour_t c;
		colour_t entry;
		logic [7:0] b0;
		logic [7:0] b1;
		logic [7:0] b2;
		logic [7:0] b3;
		pos_t y;
		pos_t x;
		int size;
		int i;
		int base;
		rom_addr_t addr;
		c = '0;
		// Higher sprite numbers are drawn over lower ones
		for (int s = 0; s < NUM_SPRITES; s++)
		begin
			b0 = sprite_ram[s * SPRITE_BYTES];
			b1 = sprite_ram[s * SPRITE_BYTES + 1];
			b2 = sprite_ram[s * SPRITE_BYTES + 2];
			b3 = sprite_ram[s * SPRITE_BYTES + 3];
			case (b0[3:2])
				2'd2: size = 8;
				2'd1: size = 16;
				2'd0: size = 32;
				default: size = 0;
			endcase
			base = (size == 8) ? ROM_BASE_8 : (size == 16) ? ROM_BASE_16 : ROM_BASE_32;
			y = {b0[0], b1};
			x = {b2[0], b3};
			i = int'(pos_t'(px - x));
			if (b0[7] && size != 0 && ay >= y && int'(ay) < int'(y) + size && i < size)
			begin
				if (b0[1])
					i = size - 1 - i;
				addr = rom_addr_t'(base + int'(b2[7:1]) * size * size
					+ int'(ay - y) * size + i);
				entry = palette[{b0[5:4], sprite_rom[addr][4:0], 1'b0}];
				if (entry[15])
					c = entry;
			end
		end
		return c;
	endfunction

	function automatic logic [24:0] expand(input colour_t c);
		logic [4:0] red;
		logic [4:0] green;
		logic [4:0] blue;
		red = c[4:0];
		green = c[9:5];
		blue = c[14:10];
		return {c[15], red, red[4:2], green, green[4:2], blue, blue[4:2]};
	endfunction

	// Whole write slot against the expected line
	always @(line_end)
	begin : compare_line
		lb_addr_t addr;
		for (int px = 0; px < 512; px++)
		begin
			addr = {exp_slot, pos_t'(px)};
			check_value($sformatf("line %0d slot %0d x %0d", exp_y, exp_slot, px),
				line_buf[addr], expected_pixel(exp_y, pos_t'(px)));
		end
	end

	// Random descriptors, all disabled
	task automatic clear_sprites();
		for (int s = 0; s < NUM_SPRITES * SPRITE_BYTES; s++)
			sprite_ram[s] = $random(seed);
		for (int s = 0; s < NUM_SPRITES; s++)
			sprite_ram[s * SPRITE_BYTES][7] = 1'b0;
	endtask

	task automatic put_sprite(input int idx, input logic [1:0] code, input logic [1:0] pal,
		input logic mirror, input logic [6:0] image, input pos_t x, input pos_t y);
		sprite_ram[idx * SPRITE_BYTES] = {1'b1, 1'b0, pal, code, mirror, y[8]};
		sprite_ram[idx * SPRITE_BYTES + 1] = y[7:0];
		sprite_ram[idx * SPRITE_BYTES + 2] = {image, x[8]};
		sprite_ram[idx * SPRITE_BYTES + 3] = x[7:0];
	endtask

	task automatic run_line(input pos_t v);
		@(posedge clk);
		hsync <= 1'b1;
		vcnt <= v;
		hcnt <= '0;
		exp_y = (v == LINE_WRAP_VCNT) ? BORDER : v + BORDER + 9'd1;
		exp_slot = ~exp_slot;
		for (int c = 1; c < LINE_CYCLES - 1; c++)
		begin
			@(posedge clk);
			if (c == 8)
				hsync <= 1'b0;
			// Readout sweeps and clears the read slot, one entry per four cycles
			hcnt <= pos_t'(c / READ_PHASES);
		end
		-> line_end;
		@(posedge clk);
	endtask

	task automatic end_test(input string name, input int errors_before);
		if (errors == errors_before)
		begin
			$display("Test %s: passed", name);
			tests_passed++;
		end
		else
		begin
			$display("Test %s: failed with %0d errors", name, errors - errors_before);
			tests_failed++;
		end
	endtask

	initial
	begin : stimulus
		logic [31:0] rnd;
		int errors_before;
		logic read_slot;
		colour_t preload [0:READ_COUNT-1];
		for (int i = 0; i < 131072; i++)
			sprite_rom[i] = $random(seed);
		for (int i = 0; i < 256; i++)
		begin
			rnd = $random(seed);
			palette[i] = {rnd[16], rnd[14:0]};
		end
		for (int i = 0; i < 1024; i++)
			line_buf[i] = '0;
		clear_sprites();
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		errors_before = errors;
		clear_sprites();
		put_sprite(5, 2'd2, 2'd1, 1'b0, 7'd3, 9'd100, 9'd40);
		run_line(9'd10);
		end_test("1 single 8x8 sprite", errors_before);

		errors_before = errors;
		clear_sprites();
		put_sprite(0, 2'd2, 2'd0, 1'b0, 7'd1, 9'd60, 9'd130);
		sprite_ram[0][7] = 1'b0;
		put_sprite(1, 2'd3, 2'd2, 1'b0, 7'd2, 9'd80, 9'd130);
		put_sprite(2, 2'd2, 2'd1, 1'b0, 7'd4, 9'd100, 9'd134);
		put_sprite(3, 2'd2, 2'd3, 1'b0, 7'd5, 9'd120, 9'd125);
		run_line(9'd100);
		// Wrap to the top border, and the line just before it
		clear_sprites();
		put_sprite(4, 2'd2, 2'd1, 1'b0, 7'd6, 9'd70, 9'd32);
		put_sprite(5, 2'd2, 2'd2, 1'b0, 7'd7, 9'd90, 9'd288);
		run_line(9'd255);
		clear_sprites();
		put_sprite(6, 2'd1, 2'd0, 1'b1, 7'd8, 9'd110, 9'd280);
		put_sprite(7, 2'd2, 2'd1, 1'b0, 7'd9, 9'd150, 9'd32);
		run_line(9'd254);
		end_test("2 rejected sprites", errors_before);

		errors_before = errors;
		clear_sprites();
		put_sprite(10, 2'd2, 2'd2, 1'b0, 7'd11, 9'd60, 9'd200);
		put_sprite(11, 2'd2, 2'd2, 1'b1, 7'd11, 9'd120, 9'd200);
		run_line(9'd170);
		end_test("3 mirrored sprite", errors_before);

		errors_before = errors;
		for (int l = 0; l < 3; l++)
		begin
			clear_sprites();
			put_sprite(20, 2'd1, 2'd1, 1'b0, 7'd5, 9'd60, 9'd60);
			put_sprite(21, 2'd0, 2'd3, 1'b1, 7'd9, 9'd100, 9'd56);
			put_sprite(22, 2'd0, 2'd0, 1'b0, 7'd90, 9'd180, 9'd56);
			run_line(pos_t'(28 + 7 * l));
		end
		end_test("4 large sprites", errors_before);

		errors_before = errors;
		for (int l = 0; l < 2; l++)
		begin
			clear_sprites();
			put_sprite(30, 2'd1, 2'd0, 1'b0, 7'd12, 9'd150, 9'd100);
			put_sprite(31, 2'd2, 2'd1, 1'b0, 7'd13, 9'd155, 9'd100);
			put_sprite(40, 2'd0, 2'd2, 1'b0, 7'd14, 9'd140, 9'd100);
			run_line(pos_t'(70 + l));
		end
		end_test("5 overlapping sprites", errors_before);

		errors_before = errors;
		read_slot = ~exp_slot;
		for (int k = 0; k < READ_COUNT; k++)
		begin
			preload[k] = $random(seed);
			line_buf[{read_slot, pos_t'(k) + BORDER}] = preload[k];
		end
		@(posedge clk);
		while (phase != 2'd2)
			@(posedge clk);
		hcnt <= '0;
		// Each entry is read on phase 0 and cleared one cycle later
		for (int k = 0; k < READ_COUNT; k++)
		begin
			repeat (READ_PHASES) @(posedge clk);
			check_value($sformatf("readout hcnt %0d", k), {a, r, g, b}, expand(preload[k]));
			check_value($sformatf("clear hcnt %0d", k),
				line_buf[{read_slot, pos_t'(k) + BORDER}], '0);
			hcnt <= pos_t'(k + 1);
		end
		end_test("6 readout", errors_before);

		$display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sprite_engine.f
rtl/sprite_pkg.sv
rtl/line_buffer_ctrl.sv
rtl/sprite_scanner.sv
rtl/sprite_renderer.sv
rtl/sprite_engine.sv
tb/sprite_engine_tb.sv

//--- Bender.yml
package:
  name: sprite_engine

sources:
  - files:
      - rtl/sprite_pkg.sv
      - rtl/line_buffer_ctrl.sv
      - rtl/sprite_scanner.sv
      - rtl/sprite_renderer.sv
      - rtl/sprite_engine.sv
  - target: test
    files:
      - tb/sprite_engine_tb.sv
